// ==== ex_stage.f ====
hdl/ex_pkg.sv
hdl/ex_uimm_bank.sv
hdl/ex_cond_eval.sv
hdl/ex_alu.sv
hdl/ex_pipe_reg.sv
hdl/ex_stage.sv
verification/ex_checker.sv
verification/tb_ex_stage.sv

// ==== run_sim.sh ====
#!/bin/sh
set -e
cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing -f ex_stage.f --top-module tb_ex_stage -o tb_ex_stage
./obj_dir/tb_ex_stage > sim.log 2>&1
cat sim.log

if grep -qx "Simulation passed" sim.log; then
    echo "Result: pass"
else
    echo "Result: fail, see sim.log"
    exit 1
fi

// ==== verification/tb_ex_stage.sv ====
`timescale 1ns/10ps

module tb_ex_stage
    import ex_pkg::*;
();

    localparam int CLK_PERIOD   = 8;
    localparam int RESET_CYCLES = 4;
    localparam int NUM_CYCLES   = 3000;
    localparam int WATCHDOG_NS  = (NUM_CYCLES + 100) * CLK_PERIOD;

    logic        iw_clk;
    logic        iw_rst;
    opc_t        opc;
    cc_t         cc;
    imm12_t      imm12;
    data_t       src_val;
    data_t       tgt_val;
    flags_t      flags_in;
    reg_idx_t    tgt_gp;
    logic        tgt_gp_we;
    logic        stall;
    logic        flush;
    reg_idx_t    wb_tgt_gp;
    logic        wb_tgt_gp_we;
    data_t       wb_result;
    flags_t      wb_flags;
    logic        wb_flags_we;
    int          error_count;
    int          check_count;
    int          seed;
    int          i;
    logic [31:0] rnd;
    opc_t        prev_opc;

    ex_stage ex_stage_i (.*);

    ex_checker checker_i (.*);

    initial begin
        iw_clk = 1'b0;
        forever #(CLK_PERIOD / 2) iw_clk = ~iw_clk;
    end

    task automatic new_instruction();
        logic [31:0] pick;
        logic [31:0] undef;
        pick = $random(seed);
        pick = pick % 20;
        // Bank loads are often followed by one of their users
        if ((prev_opc == OPC_LUIUI) && (pick < 10)) begin
            opc = (pick < 5) ? OPC_MOVUI : OPC_ADDUI;
        end else if (pick < 16) begin
            opc = pick[7:0];
        end else begin
            undef = $random(seed);
            undef = 32'h10 + undef % 240;
            opc   = undef[7:0];
        end
        rnd       = $random(seed);
        cc        = rnd[3:0];
        imm12     = rnd[15:4];
        flags_in  = rnd[19:16];
        tgt_gp    = rnd[23:20];
        tgt_gp_we = rnd[24];
        rnd       = $random(seed);
        src_val   = rnd[23:0];
        rnd       = $random(seed);
        tgt_val   = rnd[23:0];
        // Shift amounts lean toward the edges of the range
        pick = $random(seed);
        case (pick % 8)
            0: src_val[SHAMT_W-1:0] = 5'd0;
            1: src_val[SHAMT_W-1:0] = 5'd23;
            2: src_val[SHAMT_W-1:0] = 5'd24;
            3: src_val[SHAMT_W-1:0] = 5'd31;
            4: src_val = '0;
            5: tgt_val = src_val;
            default: begin
            end
        endcase
        prev_opc = opc;
    endtask

    initial begin
        seed      = 76;
        iw_rst    = 1'b1;
        opc       = OPC_NOP;
        cc        = '0;
        imm12     = '0;
        src_val   = '0;
        tgt_val   = '0;
        flags_in  = '0;
        tgt_gp    = '0;
        tgt_gp_we = 1'b0;
        stall     = 1'b0;
        flush     = 1'b0;
        prev_opc  = OPC_NOP;
        repeat (RESET_CYCLES) @(posedge iw_clk);
        for (i = 0; i < NUM_CYCLES; i++) begin
            @(negedge iw_clk);
            iw_rst = 1'b0;
            // A stalled instruction stays on the inputs until it is taken
            if (!stall || flush) begin
                new_instruction();
            end
            rnd   = $random(seed);
            stall = (rnd % 8 == 0);
            rnd   = $random(seed);
            flush = (rnd % 20 == 0);
        end
        @(negedge iw_clk);
        opc   = OPC_NOP;
        stall = 1'b0;
        flush = 1'b0;
        repeat (3) @(negedge iw_clk);
        @(posedge iw_clk);
        $display("Checks: %0d, errors: %0d", check_count, error_count);
        if ((error_count == 0) && (check_count > 0)) begin
            $display("Simulation passed");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

    initial begin
        #(WATCHDOG_NS);
        $display("Timeout: the run did not finish within %0d ns", WATCHDOG_NS);
        $display("Simulation failed");
        $finish;
    end

endmodule

// ==== verification/ex_checker.sv ====
`timescale 1ns/10ps

module ex_checker
    import ex_pkg::*;
(
    input  logic     iw_clk,
    input  logic     iw_rst,
    input  opc_t     opc,
    input  cc_t      cc,
    input  imm12_t   imm12,
    input  data_t    src_val,
    input  data_t    tgt_val,
    input  flags_t   flags_in,
    input  reg_idx_t tgt_gp,
    input  logic     tgt_gp_we,
    input  logic     stall,
    input  logic     flush,
    input  reg_idx_t wb_tgt_gp,
    input  logic     wb_tgt_gp_we,
    input  data_t    wb_result,
    input  flags_t   wb_flags,
    input  logic     wb_flags_we,
    output int       error_count,
    output int       check_count
);

    // Model of the upper-immediate bank and the stage output register
    imm12_t   m_bank;
    reg_idx_t m_tgt_gp;
    logic     m_tgt_gp_we;
    data_t    m_result;
    flags_t   m_flags;
    logic     m_flags_we;
    logic     ready = 1'b0;

    initial begin
        error_count = 0;
        check_count = 0;
    end

    function automatic logic cond_taken(input cc_t code, input flags_t f);
        logic lt;
        lt = f[FLAG_N] ^ f[FLAG_V];
        case (code)
            CC_RA:   return 1'b1;
            CC_EQ:   return f[FLAG_Z];
            CC_NE:   return !f[FLAG_Z];
            CC_LT:   return lt;
            CC_GT:   return !f[FLAG_Z] && !lt;
            CC_GE:   return !lt;
            CC_LE:   return f[FLAG_Z] || lt;
            CC_BT:   return f[FLAG_C];
            CC_AT:   return !f[FLAG_C] && !f[FLAG_Z];
            CC_BE:   return f[FLAG_C] || f[FLAG_Z];
            CC_AE:   return !f[FLAG_C];
            default: return 1'b0;
        endcase
    endfunction

    // Expected result and flags of the instruction on the inputs
    task automatic model_op(output data_t res, output flags_t fl, output logic we);
        data_t       imm;
        logic [31:0] wide;
        int          a;
        int          b;
        int          lim;
        int          amt;
        int          k;
        imm = {m_bank, imm12};
        a   = {{8{src_val[DATA_W-1]}}, src_val};
        b   = {{8{tgt_val[DATA_W-1]}}, tgt_val};
        lim = 1 << (DATA_W - 1);
        amt = {27'b0, src_val[SHAMT_W-1:0]};
        res = '0;
        fl  = '0;
        we  = 1'b0;
        case (opc)
            OPC_ADDUR, OPC_ADDSR: begin
                wide = {8'b0, src_val} + {8'b0, tgt_val};
                res  = wide[DATA_W-1:0];
                we   = 1'b1;
                if (opc == OPC_ADDUR) begin
                    fl[FLAG_C] = wide[DATA_W];
                end else begin
                    fl[FLAG_N] = res[DATA_W-1];
                    fl[FLAG_V] = ((a + b) >= lim) || ((a + b) < -lim);
                end
            end
            OPC_SUBUR, OPC_SUBSR: begin
                res = tgt_val - src_val;
                we  = 1'b1;
                if (opc == OPC_SUBUR) begin
                    fl[FLAG_C] = (tgt_val < src_val);
                end else begin
                    fl[FLAG_N] = res[DATA_W-1];
                    fl[FLAG_V] = ((b - a) >= lim) || ((b - a) < -lim);
                end
            end
            OPC_CMPUR: begin
                fl[FLAG_Z] = (src_val == tgt_val);
                fl[FLAG_C] = (src_val < tgt_val);
                we         = 1'b1;
            end
            OPC_ANDUR: begin
                res = src_val & tgt_val;
                we  = 1'b1;
            end
            OPC_ORUR: begin
                res = src_val | tgt_val;
                we  = 1'b1;
            end
            OPC_XORUR: begin
                res = src_val ^ tgt_val;
                we  = 1'b1;
            end
            OPC_NOTUR: begin
                res = ~tgt_val;
                we  = 1'b1;
            end
            OPC_SHLUR, OPC_SHRUR: begin
                if (amt >= DATA_W) begin
                    we = 1'b1;
                end else begin
                    res = tgt_val;
                    // One bit per step while C keeps the bit that falls off
                    for (k = 0; k < amt; k++) begin
                        if (opc == OPC_SHLUR) begin
                            fl[FLAG_C] = res[DATA_W-1];
                            res        = res << 1;
                        end else begin
                            fl[FLAG_C] = res[0];
                            res        = res >> 1;
                        end
                    end
                    we = (src_val != '0);
                    if (!we) begin
                        fl = '0;
                    end
                end
            end
            OPC_MCCUR: begin
                if (cond_taken(cc, flags_in)) begin
                    res = src_val;
                    we  = 1'b1;
                end else begin
                    res = tgt_val;
                end
            end
            OPC_MOVUI: begin
                res = imm;
                we  = 1'b1;
            end
            OPC_ADDUI: begin
                wide       = {8'b0, tgt_val} + {8'b0, imm};
                res        = wide[DATA_W-1:0];
                fl[FLAG_C] = wide[DATA_W];
                we         = 1'b1;
            end
            default: begin
                res = '0;
            end
        endcase
        // Z follows the result whenever flags are written except for compare
        if (we && (opc != OPC_CMPUR)) begin
            fl[FLAG_Z] = (res == '0);
        end
    endtask

    task automatic clear_model();
        m_bank      = '0;
        m_tgt_gp    = '0;
        m_tgt_gp_we = 1'b0;
        m_result    = '0;
        m_flags     = '0;
        m_flags_we  = 1'b0;
    endtask

    task automatic compare_signal(input string name, input data_t exp, input data_t act);
        check_count++;
        if (exp !== act) begin
            error_count++;
            $display("** Error: time %0d ns, %s expected 0x%0h, actual 0x%0h",
                     $time, name, exp, act);
        end
    endtask

    always @(posedge iw_clk or posedge iw_rst) begin
        data_t  exp_res;
        flags_t exp_fl;
        logic   exp_we;
        if (iw_rst || flush) begin
            clear_model();
        end else if (!stall) begin
            // Uses the bank as it was before this edge
            model_op(exp_res, exp_fl, exp_we);
            if (opc == OPC_LUIUI) begin
                m_bank = imm12;
            end
            m_tgt_gp    = tgt_gp;
            m_tgt_gp_we = tgt_gp_we;
            m_result    = exp_res;
            m_flags     = exp_fl;
            m_flags_we  = exp_we;
        end
    end

    // Comparing starts once the clock has run through a rising edge
    always @(posedge iw_clk) begin
        ready <= 1'b1;
    end

    // Outputs are stable in the middle of the cycle
    always @(negedge iw_clk) begin
        if (ready) begin
            compare_signal("wb_tgt_gp", {20'b0, m_tgt_gp}, {20'b0, wb_tgt_gp});
            compare_signal("wb_tgt_gp_we", {23'b0, m_tgt_gp_we}, {23'b0, wb_tgt_gp_we});
            compare_signal("wb_result", m_result, wb_result);
            compare_signal("wb_flags", {20'b0, m_flags}, {20'b0, wb_flags});
            compare_signal("wb_flags_we", {23'b0, m_flags_we}, {23'b0, wb_flags_we});
        end
    end

endmodule

// ==== hdl/ex_stage.sv ====
`timescale 1ns/10ps

module ex_stage
    import ex_pkg::*;
(
    input  logic     iw_clk,
    input  logic     iw_rst,
    input  opc_t     opc,
    input  cc_t      cc,
    input  imm12_t   imm12,
    input  data_t    src_val,
    input  data_t    tgt_val,
    input  flags_t   flags_in,
    input  reg_idx_t tgt_gp,
    input  logic     tgt_gp_we,
    input  logic     stall,
    input  logic     flush,
    output reg_idx_t wb_tgt_gp,
    output logic     wb_tgt_gp_we,
    output data_t    wb_result,
    output flags_t   wb_flags,
    output logic     wb_flags_we
);

    data_t  imm24;
    logic   take;
    data_t  alu_result;
    flags_t alu_flags;
    logic   alu_flags_we;

    ex_uimm_bank uimm_bank_i (
        .iw_clk (iw_clk),
        .iw_rst (iw_rst),
        .opc    (opc),
        .stall  (stall),
        .flush  (flush),
        .imm12  (imm12),
        .imm24  (imm24)
    );

    ex_cond_eval cond_eval_i (
        .cc       (cc),
        .flags_in (flags_in),
        .take     (take)
    );

    ex_alu alu_i (
        .opc      (opc),
        .src_val  (src_val),
        .tgt_val  (tgt_val),
        .imm24    (imm24),
        .take     (take),
        .result   (alu_result),
        .flags    (alu_flags),
        .flags_we (alu_flags_we)
    );

    // Destination index and write request bypass the ALU
    ex_pipe_reg pipe_reg_i (
        .iw_clk       (iw_clk),
        .iw_rst       (iw_rst),
        .stall        (stall),
        .flush        (flush),
        .tgt_gp       (tgt_gp),
        .tgt_gp_we    (tgt_gp_we),
        .result       (alu_result),
        .flags        (alu_flags),
        .flags_we     (alu_flags_we),
        .wb_tgt_gp    (wb_tgt_gp),
        .wb_tgt_gp_we (wb_tgt_gp_we),
        .wb_result    (wb_result),
        .wb_flags     (wb_flags),
        .wb_flags_we  (wb_flags_we)
    );

endmodule

// ==== hdl/ex_pipe_reg.sv ====
`timescale 1ns/10ps

module ex_pipe_reg
    import ex_pkg::*;
(
    input  logic     iw_clk,
    input  logic     iw_rst,
    input  logic     stall,
    input  logic     flush,
    input  reg_idx_t tgt_gp,
    input  logic     tgt_gp_we,
    input  data_t    result,
    input  flags_t   flags,
    input  logic     flags_we,
    output reg_idx_t wb_tgt_gp,
    output logic     wb_tgt_gp_we,
    output data_t    wb_result,
    output flags_t   wb_flags,
    output logic     wb_flags_we
);

    always_ff @(posedge iw_clk or posedge iw_rst) begin
        if (iw_rst) begin
            wb_tgt_gp    <= '0;
            wb_tgt_gp_we <= 1'b0;
            wb_result    <= '0;
            wb_flags     <= '0;
            wb_flags_we  <= 1'b0;
        end else if (flush) begin
            // Flush takes priority over stall
            wb_tgt_gp    <= '0;
            wb_tgt_gp_we <= 1'b0;
            wb_result    <= '0;
            wb_flags     <= '0;
            wb_flags_we  <= 1'b0;
        end else if (!stall) begin
            wb_tgt_gp    <= tgt_gp;
            wb_tgt_gp_we <= tgt_gp_we;
            wb_result    <= result;
            wb_flags     <= flags;
            wb_flags_we  <= flags_we;
        end
    end

endmodule

// ==== hdl/ex_alu.sv ====
`timescale 1ns/10ps

module ex_alu
    import ex_pkg::*;
(
    input  opc_t   opc,
    input  data_t  src_val,
    input  data_t  tgt_val,
    input  data_t  imm24,
    input  logic   take,
    output data_t  result,
    output flags_t flags,
    output logic   flags_we
);

    // Sums carry one extra bit for the carry out
    logic [DATA_W:0]    add_ext;
    logic [DATA_W:0]    addi_ext;
    data_t              diff;

    logic [SHAMT_W-1:0] shamt;
    logic               overshift;
    logic               src_nz;

    // Shift results with the last bit shifted out kept next to them
    logic [DATA_W:0]    shl_ext;
    logic [DATA_W:0]    shr_ext;

    assign add_ext   = {1'b0, src_val} + {1'b0, tgt_val};
    assign addi_ext  = {1'b0, tgt_val} + {1'b0, imm24};
    assign diff      = tgt_val - src_val;

    assign shamt     = src_val[SHAMT_W-1:0];
    assign overshift = (shamt >= DATA_W);
    assign src_nz    = (src_val != '0);

    // Carry lands in the top bit for left shifts and the bottom bit for right shifts
    assign shl_ext   = {1'b0, tgt_val} << shamt;
    assign shr_ext   = {tgt_val, 1'b0} >> shamt;

    always_comb begin
        result   = '0;
        flags    = '0;
        flags_we = 1'b0;

        case (opc)
            OPC_ADDUR: begin
                result        = add_ext[DATA_W-1:0];
                flags[FLAG_Z] = (result == '0);
                flags[FLAG_C] = add_ext[DATA_W];
                flags_we      = 1'b1;
            end
            OPC_SUBUR: begin
                result        = diff;
                flags[FLAG_Z] = (result == '0);
                flags[FLAG_C] = (tgt_val < src_val);
                flags_we      = 1'b1;
            end
            OPC_CMPUR: begin
                flags[FLAG_Z] = (src_val == tgt_val);
                flags[FLAG_C] = (src_val < tgt_val);
                flags_we      = 1'b1;
            end
            OPC_ADDSR: begin
                result        = add_ext[DATA_W-1:0];
                flags[FLAG_Z] = (result == '0);
                flags[FLAG_N] = result[DATA_W-1];
                // Operands agree in sign but the sum does not
                flags[FLAG_V] = (src_val[DATA_W-1] == tgt_val[DATA_W-1]) &&
                                (result[DATA_W-1] != src_val[DATA_W-1]);
                flags_we      = 1'b1;
            end
            OPC_SUBSR: begin
                result        = diff;
                flags[FLAG_Z] = (result == '0);
                flags[FLAG_N] = result[DATA_W-1];
                // Operands differ in sign and the difference flips the minuend sign
                flags[FLAG_V] = (src_val[DATA_W-1] != tgt_val[DATA_W-1]) &&
                                (result[DATA_W-1] != tgt_val[DATA_W-1]);
                flags_we      = 1'b1;
            end
            OPC_ANDUR: begin
                result        = src_val & tgt_val;
                flags[FLAG_Z] = (result == '0);
                flags_we      = 1'b1;
            end
            OPC_ORUR: begin
                result        = src_val | tgt_val;
                flags[FLAG_Z] = (result == '0);
                flags_we      = 1'b1;
            end
            OPC_XORUR: begin
                result        = src_val ^ tgt_val;
                flags[FLAG_Z] = (result == '0);
                flags_we      = 1'b1;
            end
            OPC_NOTUR: begin
                result        = ~tgt_val;
                flags[FLAG_Z] = (result == '0);
                flags_we      = 1'b1;
            end
            OPC_SHLUR: begin
                if (overshift) begin
                    flags[FLAG_Z] = 1'b1;
                    flags_we      = 1'b1;
                end else begin
                    result = shl_ext[DATA_W-1:0];
                    // Zero source leaves the flags alone
                    if (src_nz) begin
                        flags[FLAG_C] = shl_ext[DATA_W];
                        flags[FLAG_Z] = (result == '0);
                        flags_we      = 1'b1;
                    end
                end
            end
            OPC_SHRUR: begin
                if (overshift) begin
                    flags[FLAG_Z] = 1'b1;
                    flags_we      = 1'b1;
                end else begin
                    result = shr_ext[DATA_W:1];
                    if (src_nz) begin
                        flags[FLAG_C] = shr_ext[0];
                        flags[FLAG_Z] = (result == '0);
                        flags_we      = 1'b1;
                    end
                end
            end
            OPC_MCCUR: begin
                if (take) begin
                    result        = src_val;
                    flags[FLAG_Z] = (result == '0);
                    flags_we      = 1'b1;
                end else begin
                    // Not taken writes the target back unchanged
                    result = tgt_val;
                end
            end
            OPC_MOVUI: begin
                result        = imm24;
                flags[FLAG_Z] = (result == '0);
                flags_we      = 1'b1;
            end
            OPC_ADDUI: begin
                result        = addi_ext[DATA_W-1:0];
                flags[FLAG_Z] = (result == '0);
                flags[FLAG_C] = addi_ext[DATA_W];
                flags_we      = 1'b1;
            end
            default: begin
                // NOP, the bank load and undefined opcodes compute nothing here
                result = '0;
            end
        endcase
    end

endmodule

// ==== hdl/ex_cond_eval.sv ====
`timescale 1ns/10ps

module ex_cond_eval
    import ex_pkg::*;
(
    input  cc_t    cc,
    input  flags_t flags_in,
    output logic   take
);

    logic z;
    logic n;
    logic c;
    logic v;
    logic lt;

    assign z  = flags_in[FLAG_Z];
    assign n  = flags_in[FLAG_N];
    assign c  = flags_in[FLAG_C];
    assign v  = flags_in[FLAG_V];

    // Signed less-than from the flags of a prior subtract
    assign lt = n ^ v;

    always_comb begin
        case (cc)
            CC_RA:   take = 1'b1;
            CC_EQ:   take = z;
            CC_NE:   take = ~z;
            CC_LT:   take = lt;
            CC_GT:   take = ~z & ~lt;
            CC_GE:   take = ~lt;
            CC_LE:   take = z | lt;
            // Unsigned conditions use C as borrow
            CC_BT:   take = c;
            CC_AT:   take = ~c & ~z;
            CC_BE:   take = c | z;
            CC_AE:   take = ~c;
            default: take = 1'b0;
        endcase
    end

endmodule

// ==== hdl/ex_uimm_bank.sv ====
`timescale 1ns/10ps

module ex_uimm_bank
    import ex_pkg::*;
(
    input  logic   iw_clk,
    input  logic   iw_rst,
    input  opc_t   opc,
    input  logic   stall,
    input  logic   flush,
    input  imm12_t imm12,
    output data_t  imm24
);

    // Upper 12 bits of the immediate operand
    imm12_t bank0;

    always_ff @(posedge iw_clk or posedge iw_rst) begin
        if (iw_rst) begin
            bank0 <= '0;
        end else if (flush) begin
            // A flushed path must not leak its bank into the next one
            bank0 <= '0;
        end else if (!stall && (opc == OPC_LUIUI)) begin
            bank0 <= imm12;
        end
    end

    // Bank on top, current instruction field below
    assign imm24 = {bank0, imm12};

endmodule

// ==== hdl/ex_pkg.sv ====
package ex_pkg;

    // Widths of the execute stage datapath
    localparam int DATA_W    = 24;
    localparam int FLAGS_W   = 4;
    localparam int OPC_W     = 8;
    localparam int CC_W      = 4;
    localparam int IMM12_W   = 12;
    localparam int REG_IDX_W = 4;

    // Shift amount is taken from the low bits of the source register
    localparam int SHAMT_W   = 5;

    typedef logic [DATA_W-1:0]    data_t;
    typedef logic [FLAGS_W-1:0]   flags_t;
    typedef logic [OPC_W-1:0]     opc_t;
    typedef logic [CC_W-1:0]      cc_t;
    typedef logic [IMM12_W-1:0]   imm12_t;
    typedef logic [REG_IDX_W-1:0] reg_idx_t;

    // Bit positions inside flags_t
    localparam int FLAG_Z = 0;
    localparam int FLAG_N = 1;
    localparam int FLAG_C = 2;
    localparam int FLAG_V = 3;

    localparam opc_t OPC_NOP   = 8'h00;

    // Unsigned register forms
    localparam opc_t OPC_ADDUR = 8'h01;
    localparam opc_t OPC_SUBUR = 8'h02;
    localparam opc_t OPC_CMPUR = 8'h03;

    // Signed register forms
    localparam opc_t OPC_ADDSR = 8'h04;
    localparam opc_t OPC_SUBSR = 8'h05;

    // Bitwise logic
    localparam opc_t OPC_ANDUR = 8'h06;
    localparam opc_t OPC_ORUR  = 8'h07;
    localparam opc_t OPC_XORUR = 8'h08;
    localparam opc_t OPC_NOTUR = 8'h09;

    // Logical shifts by register amount
    localparam opc_t OPC_SHLUR = 8'h0A;
    localparam opc_t OPC_SHRUR = 8'h0B;

    localparam opc_t OPC_MCCUR = 8'h0C;

    // Upper immediate load and the 24-bit immediate users
    localparam opc_t OPC_LUIUI = 8'h0D;
    localparam opc_t OPC_MOVUI = 8'h0E;
    localparam opc_t OPC_ADDUI = 8'h0F;

    // Condition codes with 11 to 15 left unused
    localparam cc_t CC_RA = 4'd0;
    localparam cc_t CC_EQ = 4'd1;
    localparam cc_t CC_NE = 4'd2;
    localparam cc_t CC_LT = 4'd3;
    localparam cc_t CC_GT = 4'd4;
    localparam cc_t CC_GE = 4'd5;
    localparam cc_t CC_LE = 4'd6;
    localparam cc_t CC_BT = 4'd7;
    localparam cc_t CC_AT = 4'd8;
    localparam cc_t CC_BE = 4'd9;
    localparam cc_t CC_AE = 4'd10;

endpackage
